/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
TOP       ?= tb_mac_rx
FILELIST  ?= mac_rx.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := SOME TESTS FAILED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Result: FAIL"; exit 1; else echo "Result: PASS"; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* hw/crc32_rx.sv */
// FCS is expected high byte first as the inverted CRC; crc_err holds until the next first byte
`timescale 1ns/100ps
`include "mac_rx_settings.svh"

module crc32_rx (
    input  logic                  clk_125m,
    input  logic                  rst_125m,
    input  mac_rx_pkg::crc_feed_t crc_feed,
    output logic                  crc_err
);

    localparam int FCS_CNT_W = $clog2(`MAC_RX_FCS_LEN);

    mac_rx_pkg::crc_t     crc_q;
    mac_rx_pkg::crc_t     fcs_q;
    mac_rx_pkg::crc_t     fcs_full;
    mac_rx_pkg::crc_t     crc_final;
    logic [FCS_CNT_W-1:0] fcs_cnt_q;
    logic                 crc_err_q;
    logic                 data_beat;
    logic                 fcs_beat;

    // Reflected CRC-32, one byte per call, LSB first
    function automatic mac_rx_pkg::crc_t crc_byte(input mac_rx_pkg::crc_t crc_in,
                                                  input mac_rx_pkg::byte_t d);
        mac_rx_pkg::crc_t c;
        c = crc_in ^ {24'd0, d};
        for (int i = 0; i < 8; i++) begin
            c = c[0] ? ((c >> 1) ^ `MAC_RX_CRC_POLY) : (c >> 1);
        end
        return c;
    endfunction

    assign data_beat = crc_feed.valid && !crc_feed.is_fcs;
    assign fcs_beat  = crc_feed.valid && crc_feed.is_fcs && !crc_feed.first;
    assign fcs_full  = {fcs_q[23:0], crc_feed.data};
    assign crc_final = crc_q ^ `MAC_RX_CRC_XOROUT;

    // ----------------------------------------------------------
    // Running CRC and received FCS
    // ----------------------------------------------------------
    always_ff @(posedge clk_125m) begin
        if (data_beat) begin
            crc_q <= crc_byte(crc_feed.first ? `MAC_RX_CRC_INIT : crc_q, crc_feed.data);
        end
        if (fcs_beat) begin
            fcs_q <= fcs_full;
        end
    end

    // Compare once the last FCS byte is in
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            fcs_cnt_q <= '0;
            crc_err_q <= 1'b0;
        end else if (crc_feed.valid && crc_feed.first) begin
            fcs_cnt_q <= '0;
            crc_err_q <= 1'b0;
        end else if (fcs_beat) begin
            if (fcs_cnt_q == FCS_CNT_W'(`MAC_RX_FCS_LEN - 1)) begin
                fcs_cnt_q <= '0;
                crc_err_q <= (fcs_full != crc_final);
            end else begin
                fcs_cnt_q <= fcs_cnt_q + 1'b1;
            end
        end
    end

    assign crc_err = crc_err_q;

endmodule

/* hw/frame_parser.sv */
// Lengths outside 14..MAC_RX_MAX_BODY are unsupported; an eop byte is never forwarded as body
`timescale 1ns/100ps
`include "mac_rx_settings.svh"

module frame_parser (
    input  logic                     clk_125m,
    input  logic                     rst_125m,
    input  mac_rx_pkg::rx_beat_t     frame_beat,
    output mac_rx_pkg::crc_feed_t    crc_feed,
    output mac_rx_pkg::rx_beat_t     payload,
    output logic                     frame_done,
    output mac_rx_pkg::frame_flags_t flags,
    output mac_rx_pkg::status_t      status
);

    mac_rx_pkg::parse_state_t state_q;
    mac_rx_pkg::parse_state_t cur_state;
    mac_rx_pkg::parse_state_t next_state;
    mac_rx_pkg::len_t         cnt_q;
    mac_rx_pkg::len_t         pos;
    mac_rx_pkg::len_t         len_q;
    mac_rx_pkg::len_t         len_cur;
    mac_rx_pkg::byte_t        seq_hi_q;
    mac_rx_pkg::seq_t         seq_cur;
    mac_rx_pkg::seq_t         prev_seq_q;
    mac_rx_pkg::status_t      status_q;
    mac_rx_pkg::byte_t        data_q;
    logic                     start;
    logic                     body_last;
    logic                     closing;
    logic                     body_byte;
    logic                     len_err_q;
    logic                     seq_err_q;
    logic                     done_q;
    logic                     pay_valid_q;
    logic                     pay_sop_q;
    logic                     feed_valid_q;
    logic                     feed_first_q;
    logic                     feed_fcs_q;

    // ----------------------------------------------------------
    // Position and region of the incoming byte
    // ----------------------------------------------------------
    always_comb begin
        start     = frame_beat.valid && frame_beat.sop;
        cur_state = start ? mac_rx_pkg::BODY : state_q;
        pos       = start ? '0 : cnt_q;
        // Low length byte is still on the bus at its own position
        len_cur   = (pos == mac_rx_pkg::len_t'(`MAC_RX_LEN_POS + 1)) ?
                    {len_q[15:8], frame_beat.data} : len_q;
        seq_cur   = {seq_hi_q, frame_beat.data};
        body_last = (pos >= mac_rx_pkg::len_t'(`MAC_RX_HDR_LEN - 1)) &&
                    (pos == len_cur - 16'd1);
        closing   = frame_beat.valid && (cur_state != mac_rx_pkg::IDLE) &&
                    (frame_beat.eop || cur_state == mac_rx_pkg::TAIL);
        body_byte = frame_beat.valid && (cur_state == mac_rx_pkg::BODY) && !closing;

        next_state = cur_state;
        case (cur_state)
            mac_rx_pkg::BODY: begin
                if (body_last) next_state = mac_rx_pkg::STATUS;
            end
            mac_rx_pkg::STATUS: begin
                if (pos == len_q + mac_rx_pkg::len_t'(`MAC_RX_STATUS_LEN - 1))
                    next_state = mac_rx_pkg::FCS;
            end
            mac_rx_pkg::FCS: begin
                if (pos == len_q + mac_rx_pkg::len_t'(`MAC_RX_STATUS_LEN + `MAC_RX_FCS_LEN - 1))
                    next_state = mac_rx_pkg::TAIL;
            end
            default: next_state = cur_state;
        endcase
        // End marker slot or early eop, lost eop closes here as well
        if (closing) next_state = mac_rx_pkg::IDLE;
    end

    // ----------------------------------------------------------
    // Control, header fields and checks
    // ----------------------------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            state_q      <= mac_rx_pkg::IDLE;
            cnt_q        <= '0;
            len_q        <= '0;
            prev_seq_q   <= '0;
            len_err_q    <= 1'b0;
            seq_err_q    <= 1'b0;
            done_q       <= 1'b0;
            pay_valid_q  <= 1'b0;
            pay_sop_q    <= 1'b0;
            feed_valid_q <= 1'b0;
            feed_first_q <= 1'b0;
            feed_fcs_q   <= 1'b0;
        end else begin
            done_q       <= closing;
            pay_valid_q  <= body_byte;
            pay_sop_q    <= start && !closing;
            feed_valid_q <= frame_beat.valid && !closing &&
                            (cur_state inside {mac_rx_pkg::BODY, mac_rx_pkg::STATUS,
                                               mac_rx_pkg::FCS});
            feed_first_q <= start && !closing;
            feed_fcs_q   <= (cur_state == mac_rx_pkg::FCS);
            if (frame_beat.valid) begin
                state_q <= next_state;
                cnt_q   <= pos + 16'd1;
            end
            if (start) begin
                len_err_q <= 1'b0;
                seq_err_q <= 1'b0;
            end
            if (closing) begin
                len_err_q <= (cur_state != mac_rx_pkg::TAIL) || !frame_beat.eop ||
                             (frame_beat.data != `MAC_RX_END_BYTE);
            end
            if (body_byte && pos == mac_rx_pkg::len_t'(`MAC_RX_LEN_POS)) begin
                len_q[15:8] <= frame_beat.data;
            end
            if (body_byte && pos == mac_rx_pkg::len_t'(`MAC_RX_LEN_POS + 1)) begin
                len_q <= len_cur;
            end
            // Next frame is judged against this number even when it skipped
            if (body_byte && pos == mac_rx_pkg::len_t'(`MAC_RX_SEQ_POS + 1)) begin
                seq_err_q  <= (seq_cur != prev_seq_q + 16'd1);
                prev_seq_q <= seq_cur;
            end
        end
    end

    always_ff @(posedge clk_125m) begin
        data_q <= frame_beat.data;
        if (body_byte && pos == mac_rx_pkg::len_t'(`MAC_RX_SEQ_POS)) begin
            seq_hi_q <= frame_beat.data;
        end
        if (frame_beat.valid && cur_state == mac_rx_pkg::STATUS) begin
            if (pos == len_q) status_q[15:8] <= frame_beat.data;
            else              status_q[7:0]  <= frame_beat.data;
        end
    end

    assign payload    = {pay_valid_q, pay_sop_q, 1'b0, data_q};
    assign crc_feed   = {feed_valid_q, feed_first_q, feed_fcs_q, data_q};
    assign frame_done = done_q;
    assign flags      = {len_err_q, seq_err_q};
    assign status     = status_q;

    a_done_no_payload: assert property (@(posedge clk_125m) disable iff (!rst_125m)
        frame_done |-> !payload.valid);

    a_len_range: assert property (@(posedge clk_125m) disable iff (!rst_125m)
        state_q == mac_rx_pkg::STATUS |->
            (len_q >= mac_rx_pkg::len_t'(`MAC_RX_HDR_LEN) &&
             len_q <= mac_rx_pkg::len_t'(`MAC_RX_MAX_BODY)));

endmodule

/* hw/mac_rx_pkg.sv */
// Shared types for the receive framer; no back-pressure field exists on any beat
package mac_rx_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [15:0] seq_t;
    typedef logic [15:0] len_t;
    typedef logic [15:0] status_t;
    typedef logic [31:0] crc_t;

    // Byte beat on the PCS side, between blocks and toward the FIFO
    typedef struct packed {
        logic  valid;
        logic  sop;
        logic  eop;
        byte_t data;
    } rx_beat_t;

    // Bytes for the CRC checker, FCS bytes marked separately
    typedef struct packed {
        logic  valid;
        logic  first;
        logic  is_fcs;
        byte_t data;
    } crc_feed_t;

    typedef struct packed {
        logic len_err;
        logic seq_err;
    } frame_flags_t;

    typedef enum logic [1:0] {
        HUNT,
        PREAMBLE,
        SFD_WAIT,
        IN_FRAME
    } align_state_t;

    typedef enum logic [2:0] {
        IDLE,
        BODY,
        STATUS,
        FCS,
        TAIL
    } parse_state_t;

endpackage

/* hw/mac_rx_settings.svh */
// Framing constants for the receive framer; positions are body byte indexes, CRC is reflected
`ifndef MAC_RX_SETTINGS_SVH
`define MAC_RX_SETTINGS_SVH

// ----------------------------------------------------------
// Framing bytes
// ----------------------------------------------------------
`define MAC_RX_PREAMBLE_BYTE 8'h55
`define MAC_RX_PREAMBLE_LEN  7
`define MAC_RX_SFD_BYTE      8'hD5
`define MAC_RX_END_BYTE      8'hFD

// Header fields, high byte first
`define MAC_RX_SEQ_POS       10
`define MAC_RX_LEN_POS       12
`define MAC_RX_HDR_LEN       14

// Sections that follow the body
`define MAC_RX_STATUS_LEN    2
`define MAC_RX_FCS_LEN       4
`define MAC_RX_MAX_BODY      1500

`define MAC_RX_CRC_POLY      32'hEDB8_8320
`define MAC_RX_CRC_INIT      32'hFFFF_FFFF
`define MAC_RX_CRC_XOROUT    32'hFFFF_FFFF

`endif

/* hw/mac_rx_top.sv */
// Body bytes leave 3 cycles after entry; trailer follows the end marker at +3 and +4
`timescale 1ns/100ps

module mac_rx_top (
    input  logic                 clk_125m,
    input  logic                 rst_125m,
    input  mac_rx_pkg::rx_beat_t pcs_rx,
    input  logic                 cfg_err,
    output mac_rx_pkg::rx_beat_t fifo_rx
);

    mac_rx_pkg::rx_beat_t     frame_beat;
    mac_rx_pkg::crc_feed_t    crc_feed;
    mac_rx_pkg::rx_beat_t     payload;
    mac_rx_pkg::frame_flags_t flags;
    mac_rx_pkg::status_t      status;
    logic                     frame_done;
    logic                     crc_err;

    // ----------------------------------------------------------
    // Alignment and parsing
    // ----------------------------------------------------------
    rx_align u_rx_align (
        .clk_125m   (clk_125m),
        .rst_125m   (rst_125m),
        .pcs_rx     (pcs_rx),
        .frame_beat (frame_beat)
    );

    frame_parser u_frame_parser (
        .clk_125m   (clk_125m),
        .rst_125m   (rst_125m),
        .frame_beat (frame_beat),
        .crc_feed   (crc_feed),
        .payload    (payload),
        .frame_done (frame_done),
        .flags      (flags),
        .status     (status)
    );

    // ----------------------------------------------------------
    // CRC check and FIFO output
    // ----------------------------------------------------------
    crc32_rx u_crc32_rx (
        .clk_125m (clk_125m),
        .rst_125m (rst_125m),
        .crc_feed (crc_feed),
        .crc_err  (crc_err)
    );

    rx_trailer_gen u_rx_trailer_gen (
        .clk_125m   (clk_125m),
        .rst_125m   (rst_125m),
        .payload    (payload),
        .frame_done (frame_done),
        .flags      (flags),
        .status     (status),
        .crc_err    (crc_err),
        .cfg_err    (cfg_err),
        .fifo_rx    (fifo_rx)
    );

endmodule

/* hw/rx_align.sv */
// PCS stream cannot stall; a valid sop byte of 0x55 restarts the hunt in any state
`timescale 1ns/100ps
`include "mac_rx_settings.svh"

module rx_align (
    input  logic                 clk_125m,
    input  logic                 rst_125m,
    input  mac_rx_pkg::rx_beat_t pcs_rx,
    output mac_rx_pkg::rx_beat_t frame_beat
);

    mac_rx_pkg::align_state_t state_q;
    logic [2:0]               pre_cnt_q;
    logic                     first_q;
    logic                     valid_q;
    logic                     sop_q;
    logic                     eop_q;
    mac_rx_pkg::byte_t        data_q;
    logic                     is_pre;
    logic                     new_frame;
    logic                     fwd;

    assign is_pre    = (pcs_rx.data == `MAC_RX_PREAMBLE_BYTE);
    assign new_frame = pcs_rx.valid && pcs_rx.sop && is_pre;
    assign fwd       = pcs_rx.valid && (state_q == mac_rx_pkg::IN_FRAME) && !new_frame;

    // ----------------------------------------------------------
    // Preamble and SFD hunt
    // ----------------------------------------------------------
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            state_q   <= mac_rx_pkg::HUNT;
            pre_cnt_q <= '0;
            first_q   <= 1'b0;
        end else if (new_frame) begin
            state_q   <= mac_rx_pkg::PREAMBLE;
            pre_cnt_q <= 3'd1;
        end else if (pcs_rx.valid) begin
            case (state_q)
                mac_rx_pkg::PREAMBLE: begin
                    pre_cnt_q <= pre_cnt_q + 3'd1;
                    if (!is_pre || pcs_rx.eop) begin
                        state_q <= mac_rx_pkg::HUNT;
                    end else if (pre_cnt_q == 3'(`MAC_RX_PREAMBLE_LEN - 1)) begin
                        state_q <= mac_rx_pkg::SFD_WAIT;
                    end
                end
                mac_rx_pkg::SFD_WAIT: begin
                    if (pcs_rx.data == `MAC_RX_SFD_BYTE && !pcs_rx.eop) begin
                        state_q <= mac_rx_pkg::IN_FRAME;
                        first_q <= 1'b1;
                    end else begin
                        state_q <= mac_rx_pkg::HUNT;
                    end
                end
                mac_rx_pkg::IN_FRAME: begin
                    first_q <= 1'b0;
                    if (pcs_rx.eop) begin
                        state_q <= mac_rx_pkg::HUNT;
                    end
                end
                default: state_q <= mac_rx_pkg::HUNT;
            endcase
        end
    end

    // Frame bytes only, first one after the SFD gets sop
    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            valid_q <= 1'b0;
            sop_q   <= 1'b0;
            eop_q   <= 1'b0;
        end else begin
            valid_q <= fwd;
            sop_q   <= fwd && first_q;
            eop_q   <= fwd && pcs_rx.eop;
        end
    end

    always_ff @(posedge clk_125m) begin
        data_q <= pcs_rx.data;
    end

    assign frame_beat = {valid_q, sop_q, eop_q, data_q};

    a_sop_valid: assert property (@(posedge clk_125m) disable iff (!rst_125m)
        frame_beat.sop |-> frame_beat.valid);

endmodule

/* hw/rx_trailer_gen.sv */
// Receive FIFO always accepts; cfg_err is asynchronous and passes a two-flop synchronizer
`timescale 1ns/100ps

module rx_trailer_gen (
    input  logic                     clk_125m,
    input  logic                     rst_125m,
    input  mac_rx_pkg::rx_beat_t     payload,
    input  logic                     frame_done,
    input  mac_rx_pkg::frame_flags_t flags,
    input  mac_rx_pkg::status_t      status,
    input  logic                     crc_err,
    input  logic                     cfg_err,
    output mac_rx_pkg::rx_beat_t     fifo_rx
);

    logic              cfg_meta_q;
    logic              cfg_sync_q;
    logic              trail2_q;
    logic              trail_cyc;
    logic              valid_q;
    logic              sop_q;
    logic              eop_q;
    mac_rx_pkg::byte_t data_q;

    assign trail_cyc = frame_done || trail2_q;

    always_ff @(posedge clk_125m or negedge rst_125m) begin
        if (!rst_125m) begin
            cfg_meta_q <= 1'b0;
            cfg_sync_q <= 1'b0;
            trail2_q   <= 1'b0;
            valid_q    <= 1'b0;
            sop_q      <= 1'b0;
            eop_q      <= 1'b0;
        end else begin
            cfg_meta_q <= cfg_err;
            cfg_sync_q <= cfg_meta_q;
            trail2_q   <= frame_done;
            valid_q    <= payload.valid || trail_cyc;
            sop_q      <= payload.sop && !trail_cyc;
            eop_q      <= trail2_q;
        end
    end

    // ----------------------------------------------------------
    // Output byte mux
    // ----------------------------------------------------------
    always_ff @(posedge clk_125m) begin
        if (frame_done) begin
            data_q <= status[15:8];
        end else if (trail2_q) begin
            // Error flags on top, low status nibble below
            data_q <= {cfg_sync_q, flags.len_err, flags.seq_err, crc_err, status[3:0]};
        end else begin
            data_q <= payload.data;
        end
    end

    assign fifo_rx = {valid_q, sop_q, eop_q, data_q};

    a_no_payload_in_trailer: assert property (@(posedge clk_125m) disable iff (!rst_125m)
        trail_cyc |-> !payload.valid);

endmodule

/* mac_rx.f */
+incdir+hw
hw/mac_rx_pkg.sv
hw/rx_align.sv
hw/frame_parser.sv
hw/crc32_rx.sv
hw/rx_trailer_gen.sv
hw/mac_rx_top.sv
tests/tb_mac_rx.sv

/* tests/tb_mac_rx.sv */
// Frames are separated by six idle cycles, and cfg_err only changes at the first preamble byte
`timescale 1ns/100ps
`include "mac_rx_settings.svh"

module tb_mac_rx;

    typedef enum logic [2:0] {
        K_NONE, K_BAD_FCS, K_BAD_END, K_EARLY_EOP,
        K_NO_EOP, K_SHORT_PRE, K_BAD_SFD
    } kind_t;

    // One table row, expected flags ordered {len_err, seq_err, crc_err}
    typedef struct packed {
        mac_rx_pkg::len_t    len;
        mac_rx_pkg::seq_t    seq;
        mac_rx_pkg::status_t status;
        kind_t               kind;
        logic                gaps;
        logic                cfg;
        logic [2:0]          exp_err;
    } test_t;

    localparam int NUM_TESTS   = 17;
    localparam int IDLE_CYCLES = 6;

    logic                 clk_125m;
    logic                 rst_125m;
    mac_rx_pkg::rx_beat_t pcs_rx;
    logic                 cfg_err;
    mac_rx_pkg::rx_beat_t fifo_rx;

    test_t                tests [NUM_TESTS];
    mac_rx_pkg::rx_beat_t exp_q [$];
    integer               seed;
    int                   mismatches   = 0;
    int                   other_errors = 0;
    int                   checked      = 0;
    int                   cycle_cnt    = 0;
    int                   cycle_limit  = 0;

    initial begin
        clk_125m = 1'b0;
        forever #4 clk_125m = ~clk_125m;
    end

    mac_rx_top u_dut (
        .clk_125m (clk_125m),
        .rst_125m (rst_125m),
        .pcs_rx   (pcs_rx),
        .cfg_err  (cfg_err),
        .fifo_rx  (fifo_rx)
    );

    // ----------------------------------------------------------
    // Stimulus table
    // ----------------------------------------------------------
    task automatic load_table();
        tests[0]  = '{16'd20, 16'd1,  16'hA5C3, K_NONE,      1'b0, 1'b0, 3'b000};
        tests[1]  = '{16'd14, 16'd2,  16'h1234, K_NONE,      1'b0, 1'b0, 3'b000};
        tests[2]  = '{16'd33, 16'd3,  16'h8001, K_NONE,      1'b0, 1'b0, 3'b000};
        tests[3]  = '{16'd24, 16'd4,  16'h4E2F, K_BAD_FCS,   1'b0, 1'b0, 3'b001};
        tests[4]  = '{16'd18, 16'd5,  16'h0F0F, K_NONE,      1'b0, 1'b0, 3'b000};
        // Sequence 6 skipped
        tests[5]  = '{16'd22, 16'd7,  16'h7766, K_NONE,      1'b0, 1'b0, 3'b010};
        tests[6]  = '{16'd16, 16'd8,  16'hC0DE, K_NONE,      1'b0, 1'b0, 3'b000};
        tests[7]  = '{16'd25, 16'd9,  16'h3C5A, K_BAD_END,   1'b0, 1'b0, 3'b100};
        tests[8]  = '{16'd19, 16'd10, 16'h9E1B, K_EARLY_EOP, 1'b0, 1'b0, 3'b100};
        tests[9]  = '{16'd21, 16'd11, 16'h5AA5, K_NO_EOP,    1'b0, 1'b0, 3'b100};
        // Dropped frames never reach the sequence check
        tests[10] = '{16'd17, 16'd12, 16'h2468, K_SHORT_PRE, 1'b0, 1'b0, 3'b000};
        tests[11] = '{16'd23, 16'd40, 16'hBEEF, K_BAD_SFD,   1'b0, 1'b0, 3'b000};
        tests[12] = '{16'd15, 16'd12, 16'h1357, K_NONE,      1'b0, 1'b1, 3'b000};
        tests[13] = '{16'd40, 16'd13, 16'hF00D, K_NONE,      1'b1, 1'b0, 3'b000};
        tests[14] = '{16'd28, 16'd15, 16'h6A6A, K_BAD_FCS,   1'b1, 1'b0, 3'b011};
        tests[15] = '{16'd30, 16'd16, 16'hD1E7, K_NO_EOP,    1'b1, 1'b1, 3'b100};
        tests[16] = '{16'd14, 16'd17, 16'h2BAD, K_NONE,      1'b1, 1'b0, 3'b000};
    endtask

    // Bit-serial reference, LSB of each byte first
    function automatic mac_rx_pkg::crc_t crc_step(input mac_rx_pkg::crc_t crc,
                                                  input mac_rx_pkg::byte_t d);
        mac_rx_pkg::crc_t c;
        logic             fb;
        c = crc;
        for (int i = 0; i < 8; i++) begin
            fb = c[0] ^ d[i];
            c  = c >> 1;
            if (fb) begin
                c = c ^ `MAC_RX_CRC_POLY;
            end
        end
        return c;
    endfunction

    // Standard check value of CRC-32 over the ASCII digits 1 to 9
    task automatic check_reference();
        string            s;
        mac_rx_pkg::crc_t c;
        s = "123456789";
        c = `MAC_RX_CRC_INIT;
        for (int i = 0; i < s.len(); i++) begin
            c = crc_step(c, s[i]);
        end
        c = c ^ `MAC_RX_CRC_XOROUT;
        assert (c == 32'hCBF4_3926) else begin
            other_errors++;
            $display("ERROR: reference CRC-32 gives %08h on the check string", c);
        end
    endtask

    function automatic int frame_cycles(input test_t t);
        return `MAC_RX_PREAMBLE_LEN + 1 + int'(t.len) + `MAC_RX_STATUS_LEN +
               `MAC_RX_FCS_LEN + 1 + IDLE_CYCLES;
    endfunction

    // ----------------------------------------------------------
    // Driver
    // ----------------------------------------------------------
    task automatic drive_beat(input logic sop, input logic eop, input mac_rx_pkg::byte_t data);
        @(posedge clk_125m);
        pcs_rx <= {1'b1, sop, eop, data};
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk_125m);
            pcs_rx <= '0;
        end
    endtask

    task automatic send_frame(input test_t t);
        mac_rx_pkg::byte_t body [$];
        logic [9:0]        beats [$];
        mac_rx_pkg::crc_t  crc;
        mac_rx_pkg::crc_t  fcs;
        mac_rx_pkg::byte_t fcs_b;
        mac_rx_pkg::byte_t tail;
        int                pre_len;
        logic              dropped;

        dropped = (t.kind == K_SHORT_PRE) || (t.kind == K_BAD_SFD);
        pre_len = (t.kind == K_SHORT_PRE) ? 5 : `MAC_RX_PREAMBLE_LEN;
        for (int i = 0; i < int'(t.len); i++) begin
            case (i)
                `MAC_RX_SEQ_POS:     body.push_back(t.seq[15:8]);
                `MAC_RX_SEQ_POS + 1: body.push_back(t.seq[7:0]);
                `MAC_RX_LEN_POS:     body.push_back(t.len[15:8]);
                `MAC_RX_LEN_POS + 1: body.push_back(t.len[7:0]);
                default:             body.push_back(8'($random(seed)));
            endcase
        end
        crc = `MAC_RX_CRC_INIT;
        foreach (body[i]) begin
            crc = crc_step(crc, body[i]);
        end
        crc = crc_step(crc, t.status[15:8]);
        crc = crc_step(crc, t.status[7:0]);
        fcs = crc ^ `MAC_RX_CRC_XOROUT;

        // Line bytes as {sop, eop, data}
        for (int i = 0; i < pre_len; i++) begin
            beats.push_back({i == 0, 1'b0, `MAC_RX_PREAMBLE_BYTE});
        end
        beats.push_back({2'b00, (t.kind == K_BAD_SFD) ? 8'hD4 : `MAC_RX_SFD_BYTE});
        foreach (body[i]) begin
            beats.push_back({2'b00, body[i]});
        end
        beats.push_back({2'b00, t.status[15:8]});
        beats.push_back({2'b00, t.status[7:0]});
        for (int i = 0; i < `MAC_RX_FCS_LEN; i++) begin
            fcs_b = fcs[31 - 8*i -: 8];
            if (t.kind == K_BAD_FCS && i == 2) begin
                fcs_b = fcs_b ^ 8'h10;
            end
            beats.push_back({1'b0, t.kind == K_EARLY_EOP, fcs_b});
            if (t.kind == K_EARLY_EOP) break;
        end
        if (t.kind != K_EARLY_EOP) begin
            tail = (t.kind == K_BAD_END) ? 8'hFE : `MAC_RX_END_BYTE;
            beats.push_back({1'b0, t.kind != K_NO_EOP, tail});
        end

        // Body bytes, then status high byte, then flags over the low status nibble
        if (!dropped) begin
            foreach (body[i]) begin
                exp_q.push_back({1'b1, i == 0, 1'b0, body[i]});
            end
            exp_q.push_back({3'b100, t.status[15:8]});
            exp_q.push_back({3'b101, t.cfg, t.exp_err, t.status[3:0]});
        end

        foreach (beats[i]) begin
            if (i > 0 && t.gaps && (($random(seed) & 32'd3) == 32'd0)) begin
                drive_idle(1);
            end
            drive_beat(beats[i][9], beats[i][8], beats[i][7:0]);
            if (i == 0) cfg_err <= t.cfg;
        end
        drive_idle(IDLE_CYCLES);
    endtask

    // ----------------------------------------------------------
    // Monitor and timeout
    // ----------------------------------------------------------
    task automatic compare_beat(input mac_rx_pkg::rx_beat_t got);
        mac_rx_pkg::rx_beat_t exp;
        assert (exp_q.size() != 0) else begin
            other_errors++;
            $display("ERROR at %0t: fifo_rx delivered byte %02h when no byte was expected",
                     $time, got.data);
        end
        if (exp_q.size() != 0) begin
            exp = exp_q.pop_front();
            checked++;
            assert (got.data == exp.data) else begin
                mismatches++;
                $display("MISMATCH at %0t: fifo_rx.data expected %02h actual %02h",
                         $time, exp.data, got.data);
            end
            assert (got.sop == exp.sop) else begin
                mismatches++;
                $display("MISMATCH at %0t: fifo_rx.sop expected %0b actual %0b",
                         $time, exp.sop, got.sop);
            end
            assert (got.eop == exp.eop) else begin
                mismatches++;
                $display("MISMATCH at %0t: fifo_rx.eop expected %0b actual %0b",
                         $time, exp.eop, got.eop);
            end
        end
    endtask

    always @(negedge clk_125m) begin
        if (rst_125m && fifo_rx.valid) begin
            compare_beat(fifo_rx);
        end
    end

    always @(posedge clk_125m) begin
        cycle_cnt++;
        if (cycle_limit != 0 && cycle_cnt >= cycle_limit) begin
            $display("ERROR: run stopped after %0d cycles with %0d output bytes outstanding",
                     cycle_cnt, exp_q.size());
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    initial begin
        seed     = 32'h6562_8250;
        rst_125m = 1'b0;
        pcs_rx   = '0;
        cfg_err  = 1'b0;
        load_table();
        check_reference();
        cycle_limit = 200;
        for (int i = 0; i < NUM_TESTS; i++) begin
            cycle_limit += 4 * frame_cycles(tests[i]);
        end
        repeat (4) @(posedge clk_125m);
        rst_125m <= 1'b1;
        drive_idle(4);
        for (int i = 0; i < NUM_TESTS; i++) begin
            send_frame(tests[i]);
        end
        while (exp_q.size() != 0) begin
            @(posedge clk_125m);
        end
        // Catch stray bytes after the last trailer
        drive_idle(10);
        $display("Checked %0d bytes: %0d mismatches, %0d other errors",
                 checked, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule
